// File: Bender.yml
package:
  name: lsu

sources:
  # RTL in compile order
  - hdl/lsu_pkg.sv
  - hdl/lsu_align.sv
  - hdl/clint_timer.sv
  - hdl/axi_lite_port.sv
  - hdl/lsu_ctrl.sv
  - hdl/lsu_top.sv

  - target: test
    files:
      - test/axi_mem_model.sv
      - test/tb_lsu.sv

// File: hdl/axi_lite_port.sv
`timescale 1ns/1ns

module axi_lite_port (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cmd_valid,
    input  lsu_pkg::bus_cmd_t      cmd,
    output lsu_pkg::bus_rsp_t      rsp,
    output lsu_pkg::axi_lite_req_t axi_req,
    input  lsu_pkg::axi_lite_rsp_t axi_rsp
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_WRESP,
        ST_READ
    } state_e;

    state_e                     state;
    logic                       aw_valid;
    logic                       w_valid;
    logic                       b_ready;
    logic                       ar_valid;
    logic                       r_ready;
    logic                       done;
    logic                       aw_fire;
    logic                       w_fire;
    logic                       aw_clear;
    logic                       w_clear;
    logic [lsu_pkg::ADDR_W-1:0] addr_q;
    logic [lsu_pkg::DATA_W-1:0] wdata_q;
    logic [lsu_pkg::STRB_W-1:0] strb_q;
    logic [lsu_pkg::DATA_W-1:0] rdata_q;
    logic                       error_q;

    assign aw_fire = aw_valid & axi_rsp.aw_ready;
    assign w_fire  = w_valid & axi_rsp.w_ready;

    // address and data handshakes finish independently
    assign aw_clear = !aw_valid || aw_fire;
    assign w_clear  = !w_valid || w_fire;

    always_comb begin
        axi_req.aw_valid = aw_valid;
        axi_req.aw_addr  = addr_q;
        axi_req.w_valid  = w_valid;
        axi_req.w_data   = wdata_q;
        axi_req.w_strb   = strb_q;
        axi_req.b_ready  = b_ready;
        axi_req.ar_valid = ar_valid;
        axi_req.ar_addr  = addr_q;
        axi_req.r_ready  = r_ready;
    end

    assign rsp.done  = done;
    assign rsp.rdata = rdata_q;
    assign rsp.error = error_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
            b_ready  <= 1'b0;
            ar_valid <= 1'b0;
            r_ready  <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (cmd_valid && cmd.write) begin
                        aw_valid <= 1'b1;
                        w_valid  <= 1'b1;
                        state    <= ST_WRITE;
                    end else if (cmd_valid) begin
                        ar_valid <= 1'b1;
                        r_ready  <= 1'b1;
                        state    <= ST_READ;
                    end
                end
                ST_WRITE: begin
                    if (aw_fire) begin
                        aw_valid <= 1'b0;
                    end
                    if (w_fire) begin
                        w_valid <= 1'b0;
                    end
                    if (aw_clear && w_clear) begin
                        b_ready <= 1'b1;
                        state   <= ST_WRESP;
                    end
                end
                ST_WRESP: begin
                    if (axi_rsp.b_valid) begin
                        b_ready <= 1'b0;
                        done    <= 1'b1;
                        state   <= ST_IDLE;
                    end
                end
                ST_READ: begin
                    if (ar_valid && axi_rsp.ar_ready) begin
                        ar_valid <= 1'b0;
                    end
                    // r_ready is high for the whole read
                    if (axi_rsp.r_valid) begin
                        ar_valid <= 1'b0;
                        r_ready  <= 1'b0;
                        done     <= 1'b1;
                        state    <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // command payload and captured response
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && cmd_valid) begin
            addr_q  <= cmd.addr;
            wdata_q <= cmd.wdata;
            strb_q  <= cmd.strb;
        end
        if (state == ST_WRESP && axi_rsp.b_valid) begin
            rdata_q <= '0;
            error_q <= (axi_rsp.b_resp != lsu_pkg::RESP_OKAY);
        end else if (state == ST_READ && axi_rsp.r_valid) begin
            rdata_q <= axi_rsp.r_data;
            error_q <= (axi_rsp.r_resp != lsu_pkg::RESP_OKAY);
        end
    end

endmodule

// File: hdl/clint_timer.sv
`timescale 1ns/1ns

module clint_timer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cmd_valid,
    input  lsu_pkg::bus_cmd_t cmd,
    output lsu_pkg::bus_rsp_t rsp
);

    logic [63:0]                mtime;
    logic                       done;
    logic [lsu_pkg::DATA_W-1:0] rdata_q;
    logic [lsu_pkg::DATA_W-1:0] word_sel;

    // free running, counts from zero after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    // addr bit 2 picks the high word
    assign word_sel = cmd.addr[2] ? mtime[63:32] : mtime[31:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= cmd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            // writes are acked and dropped
            rdata_q <= cmd.write ? '0 : word_sel;
        end
    end

    assign rsp.done  = done;
    assign rsp.rdata = rdata_q;
    assign rsp.error = 1'b0;

endmodule

// File: hdl/lsu_align.sv
`timescale 1ns/1ns

module lsu_align (
    input  lsu_pkg::lsu_size_e          size,
    input  logic                        sign,
    input  logic [1:0]                  addr_lo,
    input  logic [lsu_pkg::DATA_W-1:0]  wdata,
    output logic [lsu_pkg::DATA_W-1:0]  wdata_lane,
    output logic [lsu_pkg::STRB_W-1:0]  wstrb,
    input  logic [lsu_pkg::DATA_W-1:0]  rdata_raw,
    output logic [lsu_pkg::DATA_W-1:0]  rdata
);

    // byte offset in bits
    logic [4:0]                 shamt;
    logic [lsu_pkg::DATA_W-1:0] rdata_shift;

    assign shamt = {addr_lo, 3'b000};

    // store side: move data up to its lanes
    assign wdata_lane = wdata << shamt;

    always_comb begin
        case (size)
            lsu_pkg::SIZE_BYTE: begin
                wstrb = 4'b0001 << addr_lo;
            end
            lsu_pkg::SIZE_HALF: begin
                wstrb = 4'b0011 << addr_lo;
            end
            default: begin
                wstrb = 4'b1111;
            end
        endcase
    end

    // load side: bring the addressed lanes down to bit 0
    assign rdata_shift = rdata_raw >> shamt;

    always_comb begin
        case (size)
            lsu_pkg::SIZE_BYTE: begin
                rdata = {{24{sign & rdata_shift[7]}}, rdata_shift[7:0]};
            end
            lsu_pkg::SIZE_HALF: begin
                rdata = {{16{sign & rdata_shift[15]}}, rdata_shift[15:0]};
            end
            default: begin
                // full word, nothing to extend
                rdata = rdata_shift;
            end
        endcase
    end

endmodule

// File: hdl/lsu_ctrl.sv
`timescale 1ns/1ns

module lsu_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_valid,
    input  lsu_pkg::lsu_req_t  req,
    output logic               req_ready,
    output logic               resp_valid,
    output lsu_pkg::lsu_resp_t resp,
    output logic               axi_cmd_valid,
    output logic               clint_cmd_valid,
    output lsu_pkg::bus_cmd_t  cmd,
    input  lsu_pkg::bus_rsp_t  axi_rsp_in,
    input  lsu_pkg::bus_rsp_t  clint_rsp_in
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CMD,
        ST_WAIT
    } state_e;

    state_e                     state;
    lsu_pkg::lsu_req_t          req_q;
    logic                       is_clint;
    logic                       clint_store;
    lsu_pkg::bus_rsp_t          tgt_rsp;
    logic [lsu_pkg::DATA_W-1:0] wdata_lane;
    logic [lsu_pkg::STRB_W-1:0] wstrb;
    logic [lsu_pkg::DATA_W-1:0] load_data;

    // address decode on the registered request
    assign is_clint = (req_q.addr >= lsu_pkg::CLINT_BASE) &&
                      (req_q.addr <= lsu_pkg::CLINT_END);

    // timer is read only, stores never reach it
    assign clint_store = is_clint & req_q.write;

    // one request in flight at most
    assign req_ready = (state == ST_IDLE);

    assign axi_cmd_valid   = (state == ST_CMD) && !is_clint;
    assign clint_cmd_valid = (state == ST_CMD) && is_clint && !req_q.write;

    // completion from whichever target got the command
    assign tgt_rsp = is_clint ? clint_rsp_in : axi_rsp_in;

    lsu_align i_align (
        .size       (req_q.size),
        .sign       (req_q.sign),
        .addr_lo    (req_q.addr[1:0]),
        .wdata      (req_q.wdata),
        .wdata_lane (wdata_lane),
        .wstrb      (wstrb),
        .rdata_raw  (tgt_rsp.rdata),
        .rdata      (load_data)
    );

    always_comb begin
        cmd.write = req_q.write;
        cmd.addr  = {req_q.addr[lsu_pkg::ADDR_W-1:2], 2'b00};
        cmd.wdata = wdata_lane;
        cmd.strb  = wstrb;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req_valid) begin
                        state <= ST_CMD;
                    end
                end
                ST_CMD: begin
                    if (clint_store) begin
                        // answered right away with an error
                        resp_valid <= 1'b1;
                        state      <= ST_IDLE;
                    end else begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (tgt_rsp.done) begin
                        resp_valid <= 1'b1;
                        state      <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // request and response payload
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_q <= req;
        end
        if (state == ST_CMD && clint_store) begin
            resp.rdata <= '0;
            resp.error <= 1'b1;
        end else if (state == ST_WAIT && tgt_rsp.done) begin
            resp.rdata <= req_q.write ? '0 : load_data;
            resp.error <= tgt_rsp.error;
        end
    end

endmodule

// File: hdl/lsu_pkg.sv
package lsu_pkg;

    // bus widths
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned STRB_W = DATA_W / 8;

    // CLINT window, mtime low word at base, high word at base + 4
    localparam logic [ADDR_W-1:0] CLINT_BASE = 32'ha000_0048;
    localparam logic [ADDR_W-1:0] CLINT_END  = 32'ha000_004f;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } lsu_size_e;

    // request from the core
    typedef struct packed {
        logic              write;
        logic              sign;
        lsu_size_e         size;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } lsu_req_t;

    // response to the core
    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              error;
    } lsu_resp_t;

    // controller to target, addr is word aligned and data already in lanes
    typedef struct packed {
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] strb;
    } bus_cmd_t;

    // target completion, done pulses once per command
    typedef struct packed {
        logic              done;
        logic [DATA_W-1:0] rdata;
        logic              error;
    } bus_rsp_t;

    // master driven AXI4-Lite signals
    typedef struct packed {
        logic              aw_valid;
        logic [ADDR_W-1:0] aw_addr;
        logic              w_valid;
        logic [DATA_W-1:0] w_data;
        logic [STRB_W-1:0] w_strb;
        logic              b_ready;
        logic              ar_valid;
        logic [ADDR_W-1:0] ar_addr;
        logic              r_ready;
    } axi_lite_req_t;

    // slave driven AXI4-Lite signals
    typedef struct packed {
        logic              aw_ready;
        logic              w_ready;
        logic              b_valid;
        logic [1:0]        b_resp;
        logic              ar_ready;
        logic              r_valid;
        logic [DATA_W-1:0] r_data;
        logic [1:0]        r_resp;
    } axi_lite_rsp_t;

endpackage

// File: hdl/lsu_top.sv
`timescale 1ns/1ns

module lsu_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    input  lsu_pkg::lsu_req_t      req,
    output logic                   req_ready,
    output logic                   resp_valid,
    output lsu_pkg::lsu_resp_t     resp,
    output lsu_pkg::axi_lite_req_t axi_req,
    input  lsu_pkg::axi_lite_rsp_t axi_rsp
);

    logic              axi_cmd_valid;
    logic              clint_cmd_valid;
    lsu_pkg::bus_cmd_t cmd;
    lsu_pkg::bus_rsp_t axi_bus_rsp;
    lsu_pkg::bus_rsp_t clint_bus_rsp;

    lsu_ctrl i_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_valid       (req_valid),
        .req             (req),
        .req_ready       (req_ready),
        .resp_valid      (resp_valid),
        .resp            (resp),
        .axi_cmd_valid   (axi_cmd_valid),
        .clint_cmd_valid (clint_cmd_valid),
        .cmd             (cmd),
        .axi_rsp_in      (axi_bus_rsp),
        .clint_rsp_in    (clint_bus_rsp)
    );

    // system memory path
    axi_lite_port i_axi_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (axi_cmd_valid),
        .cmd       (cmd),
        .rsp       (axi_bus_rsp),
        .axi_req   (axi_req),
        .axi_rsp   (axi_rsp)
    );

    // local timer
    clint_timer i_clint (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (clint_cmd_valid),
        .cmd       (cmd),
        .rsp       (clint_bus_rsp)
    );

endmodule

// File: project.f
hdl/lsu_pkg.sv
hdl/lsu_align.sv
hdl/clint_timer.sv
hdl/axi_lite_port.sv
hdl/lsu_ctrl.sv
hdl/lsu_top.sv
test/axi_mem_model.sv
test/tb_lsu.sv

// File: test/axi_mem_model.sv
`timescale 1ns/1ns

module axi_mem_model (
    input  logic                   clk,
    input  logic                   rst_n,
    input  lsu_pkg::axi_lite_req_t axi_req,
    output lsu_pkg::axi_lite_rsp_t axi_rsp
);

    // 1 KiB at 0x8000_0000, the top quarter answers SLVERR
    localparam logic [31:0] ERR_LO = 32'h8000_0300;
    localparam logic [31:0] ERR_HI = 32'h8000_03ff;

    logic [31:0] mem [0:255];
    integer      seed = 32'h8355_0055;
    logic        aw_got;
    logic        w_got;
    logic        ar_got;
    logic [1:0]  aw_dly;
    logic [1:0]  w_dly;
    logic [1:0]  ar_dly;
    logic [31:0] aw_addr_q;
    logic [31:0] w_data_q;
    logic [3:0]  w_strb_q;
    logic [31:0] ar_addr_q;
    logic        b_valid;
    logic [1:0]  b_resp;
    logic        r_valid;
    logic [31:0] r_data;
    logic [1:0]  r_resp;

    function automatic logic [1:0] next_delay(inout integer s);
        integer r;
        r = $random(s);
        return r[1:0];
    endfunction

    function automatic logic in_err(input logic [31:0] addr);
        return (addr >= ERR_LO) && (addr <= ERR_HI);
    endfunction

    // ready only once the random delay has run down
    assign axi_rsp.aw_ready = !aw_got && (aw_dly == 2'd0);
    assign axi_rsp.w_ready  = !w_got && (w_dly == 2'd0);
    assign axi_rsp.ar_ready = !ar_got && (ar_dly == 2'd0);
    assign axi_rsp.b_valid  = b_valid;
    assign axi_rsp.b_resp   = b_resp;
    assign axi_rsp.r_valid  = r_valid;
    assign axi_rsp.r_data   = r_data;
    assign axi_rsp.r_resp   = r_resp;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            ar_got  <= 1'b0;
            aw_dly  <= 2'd0;
            w_dly   <= 2'd0;
            ar_dly  <= 2'd0;
            b_valid <= 1'b0;
            b_resp  <= lsu_pkg::RESP_OKAY;
            r_valid <= 1'b0;
            r_data  <= '0;
            r_resp  <= lsu_pkg::RESP_OKAY;
        end else begin
            if (axi_req.aw_valid && !aw_got) begin
                if (aw_dly == 2'd0) begin
                    aw_got    <= 1'b1;
                    aw_addr_q <= axi_req.aw_addr;
                    aw_dly    <= next_delay(seed);
                end else begin
                    aw_dly <= aw_dly - 2'd1;
                end
            end
            if (axi_req.w_valid && !w_got) begin
                if (w_dly == 2'd0) begin
                    w_got    <= 1'b1;
                    w_data_q <= axi_req.w_data;
                    w_strb_q <= axi_req.w_strb;
                    w_dly    <= next_delay(seed);
                end else begin
                    w_dly <= w_dly - 2'd1;
                end
            end
            // both halves of the write are in
            if (aw_got && w_got && !b_valid) begin
                b_valid <= 1'b1;
                b_resp  <= in_err(aw_addr_q) ? lsu_pkg::RESP_SLVERR : lsu_pkg::RESP_OKAY;
            end
            if (b_valid && axi_req.b_ready) begin
                b_valid <= 1'b0;
                aw_got  <= 1'b0;
                w_got   <= 1'b0;
            end
            if (axi_req.ar_valid && !ar_got) begin
                if (ar_dly == 2'd0) begin
                    ar_got    <= 1'b1;
                    ar_addr_q <= axi_req.ar_addr;
                    ar_dly    <= next_delay(seed);
                end else begin
                    ar_dly <= ar_dly - 2'd1;
                end
            end
            if (ar_got && !r_valid) begin
                r_valid <= 1'b1;
                r_data  <= in_err(ar_addr_q) ? '0 : mem[ar_addr_q[9:2]];
                r_resp  <= in_err(ar_addr_q) ? lsu_pkg::RESP_SLVERR : lsu_pkg::RESP_OKAY;
            end
            if (r_valid && axi_req.r_ready) begin
                r_valid <= 1'b0;
                ar_got  <= 1'b0;
            end
        end
    end

    // byte lanes land only where the strobe is set
    always_ff @(posedge clk) begin
        if (aw_got && w_got && !b_valid && !in_err(aw_addr_q)) begin
            for (int i = 0; i < 4; i++) begin
                if (w_strb_q[i]) begin
                    mem[aw_addr_q[9:2]][8*i +: 8] <= w_data_q[8*i +: 8];
                end
            end
        end
    end

endmodule

// File: test/tb_lsu.sv
`timescale 1ns/1ns

module tb_lsu;

    localparam int          WAIT_LIMIT = 200;
    localparam logic [31:0] MEM_BASE   = 32'h8000_0000;
    localparam logic [31:0] ERR_ADDR   = 32'h8000_0310;

    logic                   clk;
    logic                   rst_n;
    logic                   req_valid;
    lsu_pkg::lsu_req_t      req;
    logic                   req_ready;
    logic                   resp_valid;
    lsu_pkg::lsu_resp_t     resp;
    lsu_pkg::axi_lite_req_t axi_req;
    lsu_pkg::axi_lite_rsp_t axi_rsp;

    integer             seed = 32'h8355_0055;
    int                 errors;
    int                 checks;
    int                 tests;
    int                 timeouts;
    int                 errors_at_start;
    logic               clint_busy;
    logic [7:0]         shadow [0:1023];
    logic [3:0]         last_strb;
    logic [31:0]        last_wdata;
    logic [31:0]        last_aw_addr;
    logic [31:0]        last_ar_addr;
    lsu_pkg::lsu_resp_t last_resp;
    int                 last_latency;

    lsu_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp       (resp),
        .axi_req    (axi_req),
        .axi_rsp    (axi_rsp)
    );

    axi_mem_model i_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .axi_req (axi_req),
        .axi_rsp (axi_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // AW, W and AR beats as seen on the bus
    always @(posedge clk) begin
        if (axi_req.aw_valid && axi_rsp.aw_ready) begin
            last_aw_addr <= axi_req.aw_addr;
        end
        if (axi_req.w_valid && axi_rsp.w_ready) begin
            last_strb  <= axi_req.w_strb;
            last_wdata <= axi_req.w_data;
        end
        if (axi_req.ar_valid && axi_rsp.ar_ready) begin
            last_ar_addr <= axi_req.ar_addr;
        end
    end

    // valid holds with stable payload until ready
    assert property (@(posedge clk) disable iff (!rst_n)
        (axi_req.aw_valid && !axi_rsp.aw_ready) |=>
        (axi_req.aw_valid && $stable(axi_req.aw_addr)))
    else begin
        errors++;
        $display("%0t: aw_valid dropped or aw_addr changed before aw_ready", $time);
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (axi_req.w_valid && !axi_rsp.w_ready) |=>
        (axi_req.w_valid && $stable(axi_req.w_data) && $stable(axi_req.w_strb)))
    else begin
        errors++;
        $display("%0t: w_valid dropped or write data changed before w_ready", $time);
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (axi_req.ar_valid && !axi_rsp.ar_ready) |=>
        (axi_req.ar_valid && $stable(axi_req.ar_addr)))
    else begin
        errors++;
        $display("%0t: ar_valid dropped or ar_addr changed before ar_ready", $time);
    end

    // req_ready comes back only together with the response
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(req_ready) |-> resp_valid)
    else begin
        errors++;
        $display("%0t: req_ready rose without a response", $time);
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |=> !resp_valid)
    else begin
        errors++;
        $display("%0t: resp_valid was longer than one cycle", $time);
    end

    // timer accesses stay off the AXI bus
    assert property (@(posedge clk) disable iff (!rst_n)
        clint_busy |-> (!axi_req.ar_valid && !axi_req.aw_valid))
    else begin
        errors++;
        $display("%0t: AXI valid raised during a CLINT access", $time);
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH at %0t: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic start_test();
        errors_at_start = errors;
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %-10s done, %0d errors", name, errors - errors_at_start);
    endtask

    function automatic int byte_count(input lsu_pkg::lsu_size_e size);
        case (size)
            lsu_pkg::SIZE_BYTE: return 1;
            lsu_pkg::SIZE_HALF: return 2;
            default:            return 4;
        endcase
    endfunction

    function automatic lsu_pkg::lsu_req_t make_req(input logic write, input logic sign,
                                                   input lsu_pkg::lsu_size_e size,
                                                   input logic [31:0] addr,
                                                   input logic [31:0] wdata);
        lsu_pkg::lsu_req_t r;
        r.write = write;
        r.sign  = sign;
        r.size  = size;
        r.addr  = addr;
        r.wdata = wdata;
        return r;
    endfunction

    // little endian bytes from the shadow copy and then extension
    function automatic logic [31:0] expect_load(input lsu_pkg::lsu_size_e size,
                                                input logic sign, input logic [31:0] addr);
        logic [31:0] raw;
        int          nbytes;
        int          k;
        raw    = '0;
        nbytes = byte_count(size);
        for (k = 0; k < nbytes; k++) begin
            raw[8*k +: 8] = shadow[addr[9:0] + k];
        end
        if (sign && nbytes == 1) begin
            raw[31:8] = {24{raw[7]}};
        end
        if (sign && nbytes == 2) begin
            raw[31:16] = {16{raw[15]}};
        end
        return raw;
    endfunction

    // call right after a rising edge
    task automatic run_access(input lsu_pkg::lsu_req_t r);
        int   n;
        logic accepted;
        logic seen;
        req_valid <= 1'b1;
        req       <= r;
        accepted = 1'b0;
        n        = 0;
        while (!accepted && n < WAIT_LIMIT) begin
            @(posedge clk);
            accepted = req_ready;
            n++;
        end
        req_valid <= 1'b0;
        last_latency = 0;
        if (!accepted) begin
            errors++;
            timeouts++;
            $display("timeout: request to %h was never accepted", r.addr);
            return;
        end
        seen = 1'b0;
        while (!seen && last_latency < WAIT_LIMIT) begin
            @(posedge clk);
            last_latency++;
            seen = resp_valid;
        end
        if (!seen) begin
            errors++;
            timeouts++;
            $display("timeout: no response for the request to %h", r.addr);
        end
        last_resp = resp;
    endtask

    // store through the DUT and mirror it in the shadow copy
    task automatic store_and_mirror(input lsu_pkg::lsu_size_e size, input logic [31:0] addr,
                                    input logic [31:0] data);
        int         nbytes;
        int         k;
        logic [3:0] exp_strb;
        nbytes   = byte_count(size);
        exp_strb = '0;
        run_access(make_req(1'b1, 1'b0, size, addr, data));
        check_value($sformatf("store error flag at %h", addr), last_resp.error, 0);
        check_value($sformatf("write address for %h", addr), last_aw_addr,
                    addr & ~32'h3);
        for (k = 0; k < nbytes; k++) begin
            exp_strb[addr[1:0] + k] = 1'b1;
            check_value($sformatf("write lane %0d at %h", addr[1:0] + k, addr),
                        last_wdata[8*(addr[1:0] + k) +: 8], data[8*k +: 8]);
            shadow[addr[9:0] + k] = data[8*k +: 8];
        end
        check_value($sformatf("write strobe at %h", addr), last_strb, exp_strb);
    endtask

    task automatic load_and_compare(input lsu_pkg::lsu_size_e size, input logic sign,
                                    input logic [31:0] addr);
        run_access(make_req(1'b0, sign, size, addr, '0));
        check_value($sformatf("load error flag at %h", addr), last_resp.error, 0);
        check_value($sformatf("read address for %h", addr), last_ar_addr,
                    addr & ~32'h3);
        check_value($sformatf("load size %0d sign %0b at %h", byte_count(size), sign, addr),
                    last_resp.rdata, expect_load(size, sign, addr));
    endtask

    task automatic reset_state_values();
        start_test();
        check_value("req_ready after reset", req_ready, 1);
        check_value("resp_valid after reset", resp_valid, 0);
        check_value("aw_valid after reset", axi_req.aw_valid, 0);
        check_value("w_valid after reset", axi_req.w_valid, 0);
        check_value("ar_valid after reset", axi_req.ar_valid, 0);
        finish_test("reset");
    endtask

    task automatic word_round_trip();
        int i;
        start_test();
        for (i = 0; i < 8; i++) begin
            store_and_mirror(lsu_pkg::SIZE_WORD, MEM_BASE + 4 * i, $random(seed));
        end
        for (i = 0; i < 8; i++) begin
            load_and_compare(lsu_pkg::SIZE_WORD, 1'b0, MEM_BASE + 4 * i);
        end
        finish_test("words");
    endtask

    task automatic sub_word_lanes();
        int          w;
        int          off;
        logic [31:0] base;
        logic [31:0] rnd;
        start_test();
        for (w = 0; w < 4; w++) begin
            base = MEM_BASE + 32'h80 + 4 * w;
            store_and_mirror(lsu_pkg::SIZE_WORD, base, $random(seed));
            for (off = 0; off < 4; off++) begin
                // odd offsets get a negative byte
                rnd    = $random(seed);
                rnd[7] = off[0];
                store_and_mirror(lsu_pkg::SIZE_BYTE, base + off, rnd);
            end
            for (off = 0; off < 4; off++) begin
                load_and_compare(lsu_pkg::SIZE_BYTE, 1'b1, base + off);
                load_and_compare(lsu_pkg::SIZE_BYTE, 1'b0, base + off);
            end
            for (off = 0; off < 4; off += 2) begin
                rnd     = $random(seed);
                rnd[15] = off[1] ^ w[0];
                store_and_mirror(lsu_pkg::SIZE_HALF, base + off, rnd);
            end
            for (off = 0; off < 4; off += 2) begin
                load_and_compare(lsu_pkg::SIZE_HALF, 1'b1, base + off);
                load_and_compare(lsu_pkg::SIZE_HALF, 1'b0, base + off);
            end
            load_and_compare(lsu_pkg::SIZE_WORD, 1'b0, base);
        end
        finish_test("sub_words");
    endtask

    task automatic clint_reads();
        logic [31:0] first;
        start_test();
        clint_busy <= 1'b1;
        run_access(make_req(1'b0, 1'b0, lsu_pkg::SIZE_WORD, lsu_pkg::CLINT_BASE, '0));
        check_value("first mtime read latency", last_latency, 3);
        check_value("first mtime read error flag", last_resp.error, 0);
        first = last_resp.rdata;
        run_access(make_req(1'b0, 1'b0, lsu_pkg::SIZE_WORD, lsu_pkg::CLINT_BASE, '0));
        check_value("second mtime read latency", last_latency, 3);
        checks++;
        assert (last_resp.rdata > first) else begin
            errors++;
            $display("MISMATCH at %0t: second mtime read %h is not above %h",
                     $time, last_resp.rdata, first);
        end
        // counter is far below 2**32 here
        run_access(make_req(1'b0, 1'b0, lsu_pkg::SIZE_WORD, lsu_pkg::CLINT_BASE + 4, '0));
        check_value("mtime high word", last_resp.rdata, 0);
        run_access(make_req(1'b1, 1'b0, lsu_pkg::SIZE_WORD, lsu_pkg::CLINT_BASE, 32'h1234));
        check_value("CLINT store error flag", last_resp.error, 1);
        clint_busy <= 1'b0;
        finish_test("clint");
    endtask

    task automatic error_window_accesses();
        start_test();
        run_access(make_req(1'b1, 1'b0, lsu_pkg::SIZE_WORD, ERR_ADDR, 32'hdead_beef));
        check_value("error window store flag", last_resp.error, 1);
        run_access(make_req(1'b0, 1'b0, lsu_pkg::SIZE_WORD, ERR_ADDR, '0));
        check_value("error window word load flag", last_resp.error, 1);
        run_access(make_req(1'b0, 1'b1, lsu_pkg::SIZE_BYTE, ERR_ADDR + 3, '0));
        check_value("error window byte load flag", last_resp.error, 1);
        finish_test("err_window");
    endtask

    initial begin
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        clint_busy = 1'b0;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        timeouts   = 0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        reset_state_values();
        word_round_trip();
        sub_word_lanes();
        clint_reads();
        error_window_accesses();
        repeat (2) @(posedge clk);
        $display("%0d tests, %0d checks, %0d errors, %0d timeouts",
                 tests, checks, errors, timeouts);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
